//--- design/rolly_pkg.sv
/*
  shared widths, types and constants for the replay-queue data cache
  addresses are word addresses laid out as {tag, index, offset}
  direct mapped, one cache, no byte enables
  stores are write-through and never allocate
*/
`default_nettype none

package rolly_pkg;

  localparam int DATA_W = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W = DATA_W * WORDS_PER_LINE;
  localparam int SETS = 8;
  localparam int MEM_LINES = 32;

  localparam int OFFSET_W = $clog2(WORDS_PER_LINE);
  localparam int INDEX_W = $clog2(SETS);
  localparam int LINE_ADDR_W = $clog2(MEM_LINES);
  localparam int TAG_W = LINE_ADDR_W - INDEX_W;
  localparam int ADDR_W = OFFSET_W + LINE_ADDR_W;

  // pointers carry one extra wrap bit on top of this
  localparam int FIFO_ELS = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_ELS);

  // cycles from req to ack at the backing memory
  localparam int MEM_DELAY = 3;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } dcache_pkt_t;

  typedef struct packed {
    logic                   we;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [OFFSET_W-1:0]    offset;
    logic [DATA_W-1:0]      wdata;
  } mem_req_t;

  typedef struct packed {
    logic               we;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic [LINE_W-1:0]  line;
  } fill_t;

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_REQ,
    MS_DROP,
    MS_DONE
  } miss_state_e;

endpackage

`default_nettype wire

//--- design/rolly_fifo.sv
/*
  replay queue with read, checkpoint and write pointers
  entries stay allocated from issue until retirement (ckpt)
  roll rewinds the read pointer to the oldest unretired entry
  enq_ready_o stays low for one cycle after reset
*/
`timescale 1ns/1ps
`default_nettype none

module rolly_fifo (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  rolly_pkg::dcache_pkt_t enq_pkt_i,
  input  logic                   enq_v_i,
  output logic                   enq_ready_o,

  output rolly_pkg::dcache_pkt_t deq_pkt_o,
  output logic                   deq_v_o,
  input  logic                   deq_yumi_i,

  input  logic                   ckpt_v_i,
  input  logic                   roll_v_i
);

  rolly_pkg::dcache_pkt_t mem_q [rolly_pkg::FIFO_ELS];

  logic [rolly_pkg::FIFO_PTR_W:0] wr_ptr_q;
  logic [rolly_pkg::FIFO_PTR_W:0] rd_ptr_q;
  logic [rolly_pkg::FIFO_PTR_W:0] ckpt_ptr_q;
  logic                           ready_en_q;
  logic                           full;
  logic                           enq;

  // occupancy counts from the checkpoint, not the read pointer
  assign full = (wr_ptr_q[rolly_pkg::FIFO_PTR_W] != ckpt_ptr_q[rolly_pkg::FIFO_PTR_W])
             && (wr_ptr_q[rolly_pkg::FIFO_PTR_W-1:0] == ckpt_ptr_q[rolly_pkg::FIFO_PTR_W-1:0]);

  assign enq_ready_o = ready_en_q && !full;
  assign enq = enq_v_i && enq_ready_o;

  assign deq_v_o = (rd_ptr_q != wr_ptr_q);
  assign deq_pkt_o = mem_q[rd_ptr_q[rolly_pkg::FIFO_PTR_W-1:0]];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      ckpt_ptr_q <= '0;
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      if (enq) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // roll wins over a same-cycle issue
      if (roll_v_i) begin
        rd_ptr_q <= ckpt_ptr_q;
      end else if (deq_yumi_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (ckpt_v_i) begin
        ckpt_ptr_q <= ckpt_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wr_ptr_q[rolly_pkg::FIFO_PTR_W-1:0]] <= enq_pkt_i;
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_arrays.sv
/*
  tag, valid and data arrays of the direct-mapped cache
  one registered read port, data valid one cycle after rd_en_i
  a read of the set being written returns the old contents
  writes take a whole line and always set the valid bit
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_arrays (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  logic                          rd_en_i,
  input  logic [rolly_pkg::INDEX_W-1:0] rd_index_i,
  output logic [rolly_pkg::TAG_W-1:0]   rd_tag_o,
  output logic                          rd_valid_o,
  output logic [rolly_pkg::LINE_W-1:0]  rd_line_o,

  input  logic                          wr_en_i,
  input  logic [rolly_pkg::INDEX_W-1:0] wr_index_i,
  input  logic [rolly_pkg::TAG_W-1:0]   wr_tag_i,
  input  logic [rolly_pkg::LINE_W-1:0]  wr_line_i
);

  logic [rolly_pkg::SETS-1:0]   valid_q;
  logic [rolly_pkg::TAG_W-1:0]  tag_q  [rolly_pkg::SETS];
  logic [rolly_pkg::LINE_W-1:0] line_q [rolly_pkg::SETS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_q[wr_index_i]  <= wr_tag_i;
      line_q[wr_index_i] <= wr_line_i;
    end
    if (rd_en_i) begin
      rd_tag_o   <= tag_q[rd_index_i];
      rd_valid_o <= valid_q[rd_index_i];
      rd_line_o  <= line_q[rd_index_i];
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_pipe.sv
/*
  two-stage blocking cache pipe: lookup reads the arrays, verify compares tags
  a load hit retires two cycles after issue
  a load miss rolls the queue back, drops lookup and waits for the fill;
  the load then comes back through the queue and hits
  a store holds verify until its write-through is done, then retires
  nothing issues behind a store while it is in flight
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_pipe (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  rolly_pkg::dcache_pkt_t        issue_pkt_i,
  input  logic                          issue_v_i,
  output logic                          issue_yumi_o,

  output logic                          retire_o,
  output logic [rolly_pkg::DATA_W-1:0]  data_o,
  output logic                          cache_miss_o,

  output rolly_pkg::mem_req_t           mreq_o,
  output logic                          mreq_v_o,
  input  logic                          mreq_done_i,
  input  rolly_pkg::fill_t              fill_i
);

  rolly_pkg::dcache_pkt_t         ls_pkt_q;
  rolly_pkg::dcache_pkt_t         vs_pkt_q;
  logic                           ls_v_q;
  logic                           vs_v_q;
  logic                           vs_missed_q;
  logic                           vs_done_q;
  logic [rolly_pkg::TAG_W-1:0]    vs_tag_q;
  logic                           vs_tag_v_q;
  logic [rolly_pkg::LINE_W-1:0]   vs_line_q;

  logic [rolly_pkg::TAG_W-1:0]    rd_tag;
  logic                           rd_valid;
  logic [rolly_pkg::LINE_W-1:0]   rd_line;

  logic                           vs_store;
  logic                           vs_hit;
  logic                           vs_adv;
  logic                           ls_store;
  logic [rolly_pkg::OFFSET_W-1:0] vs_off;
  logic [rolly_pkg::LINE_W-1:0]   merged_line;
  rolly_pkg::fill_t               arr_wr;

  assign vs_store = (vs_pkt_q.op == rolly_pkg::OP_STORE);
  assign vs_off = vs_pkt_q.addr[rolly_pkg::OFFSET_W-1:0];
  assign vs_hit = vs_tag_v_q
               && (vs_tag_q == vs_pkt_q.addr[rolly_pkg::ADDR_W-1 -: rolly_pkg::TAG_W]);
  assign ls_store = ls_v_q && (ls_pkt_q.op == rolly_pkg::OP_STORE);

  assign retire_o = vs_v_q && (vs_store ? vs_done_q : vs_hit);
  assign vs_adv = !vs_v_q || retire_o;
  assign issue_yumi_o = issue_v_i && vs_adv && !ls_store;

  assign cache_miss_o = vs_v_q && !vs_store && !vs_hit && !vs_missed_q;
  assign mreq_v_o = vs_v_q && !vs_done_q && (vs_store || !vs_hit);
  assign mreq_o = '{we:        vs_store,
                    line_addr: vs_pkt_q.addr[rolly_pkg::ADDR_W-1:rolly_pkg::OFFSET_W],
                    offset:    vs_off,
                    wdata:     vs_pkt_q.data};

  assign data_o = vs_store ? vs_pkt_q.data
                           : vs_line_q[vs_off*rolly_pkg::DATA_W +: rolly_pkg::DATA_W];

  always_comb begin
    merged_line = vs_line_q;
    merged_line[vs_off*rolly_pkg::DATA_W +: rolly_pkg::DATA_W] = vs_pkt_q.data;
  end

  // fill from the miss unit, else a store hit updating its own line
  always_comb begin
    if (fill_i.we) begin
      arr_wr = fill_i;
    end else begin
      arr_wr.we    = vs_v_q && vs_store && vs_hit && mreq_done_i;
      arr_wr.index = vs_pkt_q.addr[rolly_pkg::OFFSET_W +: rolly_pkg::INDEX_W];
      arr_wr.tag   = vs_pkt_q.addr[rolly_pkg::ADDR_W-1 -: rolly_pkg::TAG_W];
      arr_wr.line  = merged_line;
    end
  end

  dcache_arrays i_arrays (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rd_en_i    (issue_yumi_o),
    .rd_index_i (issue_pkt_i.addr[rolly_pkg::OFFSET_W +: rolly_pkg::INDEX_W]),
    .rd_tag_o   (rd_tag),
    .rd_valid_o (rd_valid),
    .rd_line_o  (rd_line),
    .wr_en_i    (arr_wr.we),
    .wr_index_i (arr_wr.index),
    .wr_tag_i   (arr_wr.tag),
    .wr_line_i  (arr_wr.line)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ls_v_q      <= 1'b0;
      vs_v_q      <= 1'b0;
      vs_missed_q <= 1'b0;
      vs_done_q   <= 1'b0;
    end else begin
      // poison on a miss, the queue replays it
      if (issue_yumi_o) begin
        ls_v_q <= 1'b1;
      end else if (vs_adv || cache_miss_o) begin
        ls_v_q <= 1'b0;
      end
      if (vs_adv) begin
        vs_v_q      <= ls_v_q;
        vs_missed_q <= 1'b0;
        vs_done_q   <= 1'b0;
      end else begin
        if (mreq_done_i && !vs_store) begin
          vs_v_q <= 1'b0;
        end
        if (cache_miss_o) begin
          vs_missed_q <= 1'b1;
        end
        if (mreq_done_i && vs_store) begin
          vs_done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_yumi_o) begin
      ls_pkt_q <= issue_pkt_i;
    end
    if (vs_adv) begin
      vs_pkt_q   <= ls_pkt_q;
      vs_tag_q   <= rd_tag;
      vs_tag_v_q <= rd_valid;
      vs_line_q  <= rd_line;
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_miss_unit.sv
/*
  runs one four-phase req/ack exchange per pipe request
  mreq_i must stay steady while mreq_v_i is high
  mreq_done_o pulses only after ack has fallen again
  a load request returns its line as a fill on the done cycle
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_unit (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  rolly_pkg::mem_req_t          mreq_i,
  input  logic                         mreq_v_i,
  output logic                         mreq_done_o,
  output rolly_pkg::fill_t             fill_o,

  output logic                         mem_req_o,
  output rolly_pkg::mem_req_t          mem_req_pkt_o,
  input  logic                         mem_ack_i,
  input  logic [rolly_pkg::LINE_W-1:0] mem_rdata_i
);

  rolly_pkg::miss_state_e       state_q;
  rolly_pkg::miss_state_e       state_d;
  rolly_pkg::mem_req_t          req_q;
  logic [rolly_pkg::LINE_W-1:0] line_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // a new req waits for the previous ack to drop
      rolly_pkg::MS_IDLE: begin
        if (mreq_v_i && !mem_ack_i) begin
          state_d = rolly_pkg::MS_REQ;
        end
      end
      rolly_pkg::MS_REQ: begin
        if (mem_ack_i) begin
          state_d = rolly_pkg::MS_DROP;
        end
      end
      rolly_pkg::MS_DROP: begin
        if (!mem_ack_i) begin
          state_d = rolly_pkg::MS_DONE;
        end
      end
      default: begin
        state_d = rolly_pkg::MS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= rolly_pkg::MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == rolly_pkg::MS_IDLE) begin
      req_q <= mreq_i;
    end
    if (state_q == rolly_pkg::MS_REQ && mem_ack_i) begin
      line_q <= mem_rdata_i;
    end
  end

  assign mem_req_o = (state_q == rolly_pkg::MS_REQ);
  assign mem_req_pkt_o = req_q;
  assign mreq_done_o = (state_q == rolly_pkg::MS_DONE);

  always_comb begin
    fill_o.we    = mreq_done_o && !req_q.we;
    fill_o.index = req_q.line_addr[rolly_pkg::INDEX_W-1:0];
    fill_o.tag   = req_q.line_addr[rolly_pkg::LINE_ADDR_W-1 -: rolly_pkg::TAG_W];
    fill_o.line  = line_q;
  end

endmodule

`default_nettype wire

//--- design/line_mem.sv
/*
  line-wide backing RAM, loaded from mem_init.hex at time zero
  ack rises MEM_DELAY cycles after req and falls once req is low
  a write updates one word as ack rises; rdata is valid while ack is high
*/
`timescale 1ns/1ps
`default_nettype none

module line_mem (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  logic                         mem_req_i,
  input  rolly_pkg::mem_req_t          mem_req_pkt_i,
  output logic                         mem_ack_o,
  output logic [rolly_pkg::LINE_W-1:0] mem_rdata_o
);

  logic [rolly_pkg::LINE_W-1:0]           mem_q [rolly_pkg::MEM_LINES];
  logic [$clog2(rolly_pkg::MEM_DELAY)-1:0] cnt_q;
  logic                                   fire;

  initial begin
    $readmemh("mem_init.hex", mem_q);
  end

  assign fire = mem_req_i && !mem_ack_o && (cnt_q == rolly_pkg::MEM_DELAY - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_ack_o <= 1'b0;
      cnt_q     <= '0;
    end else if (mem_ack_o) begin
      if (!mem_req_i) begin
        mem_ack_o <= 1'b0;
      end
    end else if (fire) begin
      mem_ack_o <= 1'b1;
      cnt_q     <= '0;
    end else if (mem_req_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      mem_rdata_o <= mem_q[mem_req_pkt_i.line_addr];
      if (mem_req_pkt_i.we) begin
        mem_q[mem_req_pkt_i.line_addr][mem_req_pkt_i.offset*rolly_pkg::DATA_W +:
          rolly_pkg::DATA_W] <= mem_req_pkt_i.wdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rolly_dcache_top.sv
/*
  replay queue in front of a blocking data cache and its backing memory
  v_o pulses once per retired operation, in program order
  no back-pressure on v_o/data_o
*/
`timescale 1ns/1ps
`default_nettype none

module rolly_dcache_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  rolly_pkg::dcache_pkt_t       dcache_pkt_i,
  input  logic                         dcache_pkt_v_i,
  output logic                         dcache_pkt_ready_o,

  output logic                         v_o,
  output logic [rolly_pkg::DATA_W-1:0] data_o
);

  rolly_pkg::dcache_pkt_t       issue_pkt;
  logic                         issue_v;
  logic                         issue_yumi;
  logic                         cache_miss;

  rolly_pkg::mem_req_t          mreq;
  logic                         mreq_v;
  logic                         mreq_done;
  rolly_pkg::fill_t             fill;

  logic                         mem_req;
  rolly_pkg::mem_req_t          mem_req_pkt;
  logic                         mem_ack;
  logic [rolly_pkg::LINE_W-1:0] mem_rdata;

  // retirement frees the queue entry
  rolly_fifo i_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .enq_pkt_i   (dcache_pkt_i),
    .enq_v_i     (dcache_pkt_v_i),
    .enq_ready_o (dcache_pkt_ready_o),
    .deq_pkt_o   (issue_pkt),
    .deq_v_o     (issue_v),
    .deq_yumi_i  (issue_yumi),
    .ckpt_v_i    (v_o),
    .roll_v_i    (cache_miss)
  );

  dcache_pipe i_pipe (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .issue_pkt_i  (issue_pkt),
    .issue_v_i    (issue_v),
    .issue_yumi_o (issue_yumi),
    .retire_o     (v_o),
    .data_o       (data_o),
    .cache_miss_o (cache_miss),
    .mreq_o       (mreq),
    .mreq_v_o     (mreq_v),
    .mreq_done_i  (mreq_done),
    .fill_i       (fill)
  );

  dcache_miss_unit i_miss (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mreq_i        (mreq),
    .mreq_v_i      (mreq_v),
    .mreq_done_o   (mreq_done),
    .fill_o        (fill),
    .mem_req_o     (mem_req),
    .mem_req_pkt_o (mem_req_pkt),
    .mem_ack_i     (mem_ack),
    .mem_rdata_i   (mem_rdata)
  );

  line_mem i_mem (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mem_req_i     (mem_req),
    .mem_req_pkt_i (mem_req_pkt),
    .mem_ack_o     (mem_ack),
    .mem_rdata_o   (mem_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/tb_model.svh
/*
  memory model and result checking, included inside the testbench module
  one 128-bit line per memory entry, word 0 in the low bits
  expected results are queued when a packet is accepted, popped at each v_o
  the first mismatch ends the run
*/
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

  logic [rolly_pkg::LINE_W-1:0] model_mem [rolly_pkg::MEM_LINES];
  logic [rolly_pkg::DATA_W-1:0] exp_q [$];

  // stores update the model in program order, at acceptance
  function automatic logic [rolly_pkg::DATA_W-1:0] apply_to_model(
    input rolly_pkg::dcache_pkt_t p
  );
    logic [rolly_pkg::LINE_ADDR_W-1:0] line_idx;
    logic [rolly_pkg::OFFSET_W-1:0]    off;
    line_idx = p.addr[rolly_pkg::ADDR_W-1:rolly_pkg::OFFSET_W];
    off = p.addr[rolly_pkg::OFFSET_W-1:0];
    if (p.op == rolly_pkg::OP_STORE) begin
      model_mem[line_idx][off*rolly_pkg::DATA_W +: rolly_pkg::DATA_W] = p.data;
      return p.data;
    end
    return model_mem[line_idx][off*rolly_pkg::DATA_W +: rolly_pkg::DATA_W];
  endfunction

  task automatic check_value(
    input string                   name,
    input logic [rolly_pkg::DATA_W-1:0] exp,
    input logic [rolly_pkg::DATA_W-1:0] act
  );
    if (exp !== act) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
    end
  endtask

`endif

//--- testbench/tb_rolly_dcache.sv
/*
  random and directed traffic into rolly_dcache_top, checked against a memory model
  run from the project root so that mem_init.hex is found
  stops at the first mismatch; a cycle limit guards against a hang
*/
`timescale 1ns/1ps
`default_nettype none

module tb_rolly_dcache;

  localparam int unsigned SEED = 32'h95c999d2;
  localparam string HEX_FILE = "mem_init.hex";
  // op counts of the five tests
  localparam int TOTAL_OPS = 20 + 9 + 48 + 17 + 300;
  localparam int CYCLE_LIMIT = 40 * TOTAL_OPS;

  logic                         clk;
  logic                         rst_n;
  rolly_pkg::dcache_pkt_t       pkt;
  logic                         pkt_v;
  logic                         pkt_ready;
  logic                         v;
  logic [rolly_pkg::DATA_W-1:0] data;

  int    cycle = 0;
  int    issue_cycle = 0;
  int    retire_cycle = 0;
  int    n_issued = 0;
  logic  watch_full = 1'b0;
  logic  saw_full = 1'b0;
  string test_name = "reset";

  `include "tb_model.svh"

  rolly_dcache_top i_dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .dcache_pkt_i       (pkt),
    .dcache_pkt_v_i     (pkt_v),
    .dcache_pkt_ready_o (pkt_ready),
    .v_o                (v),
    .data_o             (data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run aborted");
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      abort_run("timeout: cycle limit reached before all operations retired");
    end
  end

  // mid-cycle sampling, retirement before acceptance
  always @(negedge clk) begin
    if (rst_n) begin
      if (i_dut.issue_yumi) begin
        issue_cycle = cycle;
        n_issued = n_issued + 1;
      end
      if (v) begin
        retire_cycle = cycle;
        if (exp_q.size() == 0) begin
          abort_run("v_o pulsed with no operation outstanding");
        end else begin
          check_value(test_name, exp_q.pop_front(), data);
        end
      end
      if (pkt_v && pkt_ready) begin
        exp_q.push_back(apply_to_model(pkt));
      end
      if (watch_full && !pkt_ready) begin
        saw_full = 1'b1;
      end
    end
  end

  function automatic logic [rolly_pkg::ADDR_W-1:0] rand_addr(input int unsigned hi);
    int unsigned r;
    r = $urandom_range(hi, 0);
    return r[rolly_pkg::ADDR_W-1:0];
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // called and returns 1 ns after a rising edge
  task automatic send_pkt(
    input rolly_pkg::op_e               op,
    input logic [rolly_pkg::ADDR_W-1:0] addr,
    input logic [rolly_pkg::DATA_W-1:0] wdata
  );
    pkt.op = op;
    pkt.addr = addr;
    pkt.data = wdata;
    pkt_v = 1'b1;
    @(negedge clk);
    while (!pkt_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    pkt_v = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    idle(4);
  endtask

  task automatic load_sweep();
    int i;
    test_name = "load_sweep";
    for (i = 0; i < 20; i++) begin
      send_pkt(rolly_pkg::OP_LOAD, rand_addr(127), '0);
    end
    wait_drained();
  endtask

  task automatic line_reuse();
    logic [rolly_pkg::LINE_ADDR_W-1:0] line_idx;
    logic [rolly_pkg::OFFSET_W-1:0]    off;
    int unsigned                       r;
    int                                i;
    int                                issues_before;
    test_name = "line_reuse";
    r = $urandom_range(31, 0);
    line_idx = r[rolly_pkg::LINE_ADDR_W-1:0];
    off = '0;
    send_pkt(rolly_pkg::OP_LOAD, {line_idx, off}, '0);
    wait_drained();
    // line is resident, each lone load must hit
    for (i = 0; i < 4; i++) begin
      off = i[rolly_pkg::OFFSET_W-1:0];
      issues_before = n_issued;
      send_pkt(rolly_pkg::OP_LOAD, {line_idx, off}, '0);
      wait_drained();
      check_value("line_reuse issue count", 32'd1, n_issued - issues_before);
      check_value("line_reuse hit latency", 32'd2, retire_cycle - issue_cycle);
    end
    for (i = 0; i < 4; i++) begin
      off = i[rolly_pkg::OFFSET_W-1:0];
      send_pkt(rolly_pkg::OP_LOAD, {line_idx, off}, '0);
    end
    wait_drained();
  endtask

  task automatic store_mix();
    logic [rolly_pkg::ADDR_W-1:0] addr;
    int                           i;
    test_name = "store_mix";
    for (i = 0; i < 16; i++) begin
      addr = rand_addr(63);
      send_pkt(rolly_pkg::OP_STORE, addr, $urandom);
      idle($urandom_range(2, 0));
      send_pkt(rolly_pkg::OP_LOAD, addr, '0);
      send_pkt(rolly_pkg::OP_LOAD, rand_addr(63), '0);
      idle($urandom_range(2, 0));
    end
    wait_drained();
  endtask

  // set 5 with a new tag each group, so the leading load always misses
  task automatic miss_burst();
    logic [rolly_pkg::LINE_ADDR_W-1:0] line_idx;
    int                                g;
    int                                r;
    test_name = "miss_burst";
    // tag 3 first, so the walk from tag 0 starts on a miss
    send_pkt(rolly_pkg::OP_LOAD, {5'd29, 2'd0}, '0);
    wait_drained();
    for (g = 0; g < 4; g++) begin
      r = 5 + 8 * g;
      line_idx = r[rolly_pkg::LINE_ADDR_W-1:0];
      send_pkt(rolly_pkg::OP_LOAD, {line_idx, 2'd0}, '0);
      send_pkt(rolly_pkg::OP_LOAD, {line_idx, 2'd3}, '0);
      // younger ops stay in sets 0 to 3
      send_pkt(rolly_pkg::OP_STORE, rand_addr(15), $urandom);
      send_pkt(rolly_pkg::OP_LOAD, rand_addr(15), '0);
    end
    wait_drained();
  endtask

  task automatic random_traffic();
    rolly_pkg::op_e op;
    int             i;
    test_name = "random_traffic";
    saw_full = 1'b0;
    watch_full = 1'b1;
    for (i = 0; i < 300; i++) begin
      op = ($urandom_range(1, 0) == 1) ? rolly_pkg::OP_STORE : rolly_pkg::OP_LOAD;
      send_pkt(op, rand_addr(127), $urandom);
      // ops 120 to 179 go back to back
      if ((i < 120 || i >= 180) && $urandom_range(3, 0) == 0) begin
        idle($urandom_range(2, 1));
      end
    end
    wait_drained();
    watch_full = 1'b0;
    check_value("random_traffic queue full seen", 32'd1, 32'(saw_full));
  endtask

  initial begin
    rst_n = 1'b0;
    pkt = '0;
    pkt_v = 1'b0;
    void'($urandom(SEED));
    $readmemh(HEX_FILE, model_mem);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    load_sweep();
    line_reuse();
    store_mix();
    miss_burst();
    random_traffic();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_init.hex
// one 128-bit line per row, memory lines 0 to 31; word 3 on the left, word 0 on the right
03fcc00302fdc00201fec00100ffc000
07f8c00706f9c00605fac00504fbc004
0bf4c00b0af5c00a09f6c00908f7c008
0ff0c00f0ef1c00e0df2c00d0cf3c00c
13ecc01312edc01211eec01110efc010
17e8c01716e9c01615eac01514ebc014
1be4c01b1ae5c01a19e6c01918e7c018
1fe0c01f1ee1c01e1de2c01d1ce3c01c
23dcc02322ddc02221dec02120dfc020
27d8c02726d9c02625dac02524dbc024
2bd4c02b2ad5c02a29d6c02928d7c028
2fd0c02f2ed1c02e2dd2c02d2cd3c02c
33ccc03332cdc03231cec03130cfc030
37c8c03736c9c03635cac03534cbc034
3bc4c03b3ac5c03a39c6c03938c7c038
3fc0c03f3ec1c03e3dc2c03d3cc3c03c
43bcc04342bdc04241bec04140bfc040
47b8c04746b9c04645bac04544bbc044
4bb4c04b4ab5c04a49b6c04948b7c048
4fb0c04f4eb1c04e4db2c04d4cb3c04c
53acc05352adc05251aec05150afc050
57a8c05756a9c05655aac05554abc054
5ba4c05b5aa5c05a59a6c05958a7c058
5fa0c05f5ea1c05e5da2c05d5ca3c05c
639cc063629dc062619ec061609fc060
6798c0676699c066659ac065649bc064
6b94c06b6a95c06a6996c0696897c068
6f90c06f6e91c06e6d92c06d6c93c06c
738cc073728dc072718ec071708fc070
7788c0777689c076758ac075748bc074
7b84c07b7a85c07a7986c0797887c078
7f80c07f7e81c07e7d82c07d7c83c07c

//--- rolly_dcache.f
+incdir+testbench
design/rolly_pkg.sv
design/rolly_fifo.sv
design/dcache_arrays.sv
design/dcache_pipe.sv
design/dcache_miss_unit.sv
design/line_mem.sv
design/rolly_dcache_top.sv
testbench/tb_rolly_dcache.sv

//--- Makefile
SIM := obj_dir/Vtb_rolly_dcache
SRCS := $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

$(SIM): rolly_dcache.f $(SRCS)
	verilator --binary --timing -j 0 -Wno-fatal -f rolly_dcache.f \
		--top-module tb_rolly_dcache -o Vtb_rolly_dcache

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
